//--- hw/mem_pkg.sv
// data memory shared definitions
package mem_pkg;

  localparam int XLEN       = 64;
  localparam int NBYTES     = XLEN / 8;          // byte lanes per word
  localparam int OFFS_W     = $clog2(NBYTES);    // byte offset bits
  localparam int MEM_WORDS  = 256;
  localparam int WORD_IDX_W = 8;                 // addr[10:3]

  // bit 0 set means unsigned load, bits 2:1 give the size
  typedef enum logic [2:0] {
    MEM_LB   = 3'd0,
    MEM_LBU  = 3'd1,
    MEM_LH   = 3'd2,
    MEM_LHU  = 3'd3,
    MEM_LW   = 3'd4,
    MEM_LWU  = 3'd5,
    MEM_LD   = 3'd6,
    MEM_NONE = 3'd7
  } memop_e;

  // natural alignment check, used by both lanes
  function automatic logic is_aligned(memop_e op, logic [OFFS_W-1:0] off);
    logic ok;
    case (op)
      MEM_LH, MEM_LHU: ok = (off[0] == 1'b0);
      MEM_LW, MEM_LWU: ok = (off[1:0] == 2'b00);
      MEM_LD:          ok = (off == '0);
      default:         ok = 1'b1;  // bytes always fit
    endcase
    return ok;
  endfunction

endpackage

//--- hw/store_lane.sv
// store mask and data alignment
`timescale 1ns/1ps

module store_lane (
  input  logic                              i_wen,
  input  mem_pkg::memop_e                   i_memop,
  input  logic [mem_pkg::XLEN-1:0]          i_addr,
  input  logic [mem_pkg::XLEN-1:0]          i_wdata,
  output logic                              o_ram_wen,
  output logic [mem_pkg::WORD_IDX_W-1:0]    o_ram_idx,
  output logic [mem_pkg::NBYTES-1:0]        o_ram_mask,
  output logic [mem_pkg::XLEN-1:0]          o_ram_data,
  output logic                              o_misalign
);

  logic [mem_pkg::OFFS_W-1:0] off;
  logic [mem_pkg::NBYTES-1:0] base_mask;
  logic                       req;
  logic                       aligned;

  assign off     = i_addr[mem_pkg::OFFS_W-1:0];
  assign req     = i_wen && (i_memop != mem_pkg::MEM_NONE);
  assign aligned = mem_pkg::is_aligned(i_memop, off);

  assign o_ram_idx = i_addr[mem_pkg::WORD_IDX_W+mem_pkg::OFFS_W-1:mem_pkg::OFFS_W];

  // lanes covered at offset zero, signedness is irrelevant for stores
  always_comb begin
    case (i_memop)
      mem_pkg::MEM_LB, mem_pkg::MEM_LBU: base_mask = 8'h01;
      mem_pkg::MEM_LH, mem_pkg::MEM_LHU: base_mask = 8'h03;
      mem_pkg::MEM_LW, mem_pkg::MEM_LWU: base_mask = 8'h0f;
      default:                           base_mask = 8'hff;
    endcase
  end

  assign o_ram_mask = base_mask << off;
  assign o_ram_data = i_wdata << {off, 3'b000};   // byte offset to bits

  assign o_ram_wen  = req && aligned;  // misaligned stores dropped
  assign o_misalign = req && !aligned;

  always_comb begin
    if (o_ram_wen) begin
      assert (o_ram_mask != '0)
        else $error("store_lane: write enabled with empty byte mask");
    end
  end

endmodule

//--- hw/load_lane.sv
// load decode, alignment and extension
`timescale 1ns/1ps

module load_lane (
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  input  logic                              i_ren,
  input  logic                              i_block,     // store in same cycle
  input  mem_pkg::memop_e                   i_memop,
  input  logic [mem_pkg::XLEN-1:0]          i_addr,
  input  logic [mem_pkg::XLEN-1:0]          i_ram_word,
  output logic                              o_ram_ren,
  output logic [mem_pkg::WORD_IDX_W-1:0]    o_ram_idx,
  output logic                              o_misalign,
  output logic [mem_pkg::XLEN-1:0]          o_rdata,
  output logic                              o_rvalid
);

  logic                       req;
  logic                       aligned;
  logic                       s1_valid;
  logic [mem_pkg::OFFS_W-1:0] s1_off;
  mem_pkg::memop_e            s1_op;
  logic [mem_pkg::XLEN-1:0]   shifted;
  logic [mem_pkg::XLEN-1:0]   fmt;

  // stage one, issue the read
  assign req     = i_ren && !i_block && (i_memop != mem_pkg::MEM_NONE);
  assign aligned = mem_pkg::is_aligned(i_memop, i_addr[mem_pkg::OFFS_W-1:0]);

  assign o_ram_ren  = req && aligned;
  assign o_misalign = req && !aligned;
  assign o_ram_idx  = i_addr[mem_pkg::WORD_IDX_W+mem_pkg::OFFS_W-1:mem_pkg::OFFS_W];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= o_ram_ren;
    end
  end

  // follows the ram read register
  always_ff @(posedge i_clk) begin
    if (o_ram_ren) begin
      s1_off <= i_addr[mem_pkg::OFFS_W-1:0];
      s1_op  <= i_memop;
    end
  end

  // stage two, align and extend
  assign shifted = i_ram_word >> {s1_off, 3'b000};

  always_comb begin
    case (s1_op)
      mem_pkg::MEM_LB:  fmt = {{(mem_pkg::XLEN-8){shifted[7]}}, shifted[7:0]};
      mem_pkg::MEM_LBU: fmt = {{(mem_pkg::XLEN-8){1'b0}}, shifted[7:0]};
      mem_pkg::MEM_LH:  fmt = {{(mem_pkg::XLEN-16){shifted[15]}}, shifted[15:0]};
      mem_pkg::MEM_LHU: fmt = {{(mem_pkg::XLEN-16){1'b0}}, shifted[15:0]};
      mem_pkg::MEM_LW:  fmt = {{(mem_pkg::XLEN-32){shifted[31]}}, shifted[31:0]};
      mem_pkg::MEM_LWU: fmt = {{(mem_pkg::XLEN-32){1'b0}}, shifted[31:0]};
      default:          fmt = shifted;  // doubleword
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rvalid <= 1'b0;
      o_rdata  <= '0;
    end else begin
      o_rvalid <= s1_valid;
      o_rdata  <= s1_valid ? fmt : '0;  // zero between results
    end
  end

  // nothing can be in flight across reset release
  a_no_rvalid_after_reset: assert property (
    @(posedge i_clk) $rose(i_rst_n) |=> !o_rvalid
  ) else $error("load_lane: rvalid right after reset release");

endmodule

//--- hw/data_ram.sv
// byte masked word memory
`timescale 1ns/1ps

module data_ram (
  input  logic                              i_clk,
  input  logic                              i_wen,
  input  logic [mem_pkg::WORD_IDX_W-1:0]    i_widx,
  input  logic [mem_pkg::NBYTES-1:0]        i_wmask,
  input  logic [mem_pkg::XLEN-1:0]          i_wdata,
  input  logic                              i_ren,
  input  logic [mem_pkg::WORD_IDX_W-1:0]    i_ridx,
  output logic [mem_pkg::XLEN-1:0]          o_rdata
);

  logic [mem_pkg::XLEN-1:0] mem [mem_pkg::MEM_WORDS];

  // write only the selected byte lanes
  always_ff @(posedge i_clk) begin
    if (i_wen) begin
      for (int b = 0; b < mem_pkg::NBYTES; b++) begin
        if (i_wmask[b]) begin
          mem[i_widx][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ren) begin
      o_rdata <= mem[i_ridx];  // one cycle read latency
    end
  end

  // load lane must back off whenever the store lane writes
  a_no_rw_conflict: assert property (
    @(posedge i_clk) !(i_wen && i_ren)
  ) else $error("data_ram: read and write in the same cycle");

endmodule

//--- hw/mem_unit.sv
// data memory unit top
`timescale 1ns/1ps

module mem_unit (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic [mem_pkg::XLEN-1:0]     i_addr,
  input  logic [mem_pkg::XLEN-1:0]     i_wdata,
  input  mem_pkg::memop_e              i_memop,
  input  logic                         i_wen,
  input  logic                         i_ren,
  output logic [mem_pkg::XLEN-1:0]     o_rdata,
  output logic                         o_rvalid,
  output logic                         o_misalign
);

  logic                           st_wen;
  logic [mem_pkg::WORD_IDX_W-1:0] st_idx;
  logic [mem_pkg::NBYTES-1:0]     st_mask;
  logic [mem_pkg::XLEN-1:0]       st_data;
  logic                           st_misalign;

  logic                           ld_ren;
  logic [mem_pkg::WORD_IDX_W-1:0] ld_idx;
  logic                           ld_misalign;
  logic [mem_pkg::XLEN-1:0]       ram_word;

  store_lane u_store (
    .i_wen      (i_wen),
    .i_memop    (i_memop),
    .i_addr     (i_addr),
    .i_wdata    (i_wdata),
    .o_ram_wen  (st_wen),
    .o_ram_idx  (st_idx),
    .o_ram_mask (st_mask),
    .o_ram_data (st_data),
    .o_misalign (st_misalign)
  );

  load_lane u_load (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_ren      (i_ren),
    .i_block    (i_wen),     // write wins
    .i_memop    (i_memop),
    .i_addr     (i_addr),
    .i_ram_word (ram_word),
    .o_ram_ren  (ld_ren),
    .o_ram_idx  (ld_idx),
    .o_misalign (ld_misalign),
    .o_rdata    (o_rdata),
    .o_rvalid   (o_rvalid)
  );

  data_ram u_ram (
    .i_clk   (i_clk),
    .i_wen   (st_wen),
    .i_widx  (st_idx),
    .i_wmask (st_mask),
    .i_wdata (st_data),
    .i_ren   (ld_ren),
    .i_ridx  (ld_idx),
    .o_rdata (ram_word)
  );

  // one pulse a cycle after the accepting edge
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_misalign <= 1'b0;
    end else begin
      o_misalign <= st_misalign | ld_misalign;
    end
  end

endmodule

//--- testbench/tb_mem_unit.sv
// data memory unit testbench
`timescale 1ns/1ps

module tb_mem_unit;

  localparam int N_RANDOM   = 1500;
  localparam int PRE_CYCLES = 200;    // upper bound on reset plus directed part
  localparam int CLK_NS     = 100;
  localparam int FILL_WORDS = 32;     // random traffic stays inside these words

  logic                   i_clk;
  logic                   i_rst_n;
  logic [63:0]            i_addr;
  logic [63:0]            i_wdata;
  mem_pkg::memop_e        i_memop;
  logic                   i_wen;
  logic                   i_ren;
  logic [63:0]            o_rdata;
  logic                   o_rvalid;
  logic                   o_misalign;

  logic [7:0]  shadow [mem_pkg::MEM_WORDS][mem_pkg::NBYTES];
  logic        exp_mis    = 1'b0;
  logic        exp_rvalid = 1'b0;
  logic [63:0] exp_rdata  = '0;
  logic        s1_v       = 1'b0;     // load waiting in the ram read
  logic [63:0] s1_d       = '0;
  integer      seed       = 32'h1ad1c19e;
  int          err_data   = 0;
  int          err_pulse  = 0;

  mem_unit uut (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_addr     (i_addr),
    .i_wdata    (i_wdata),
    .i_memop    (i_memop),
    .i_wen      (i_wen),
    .i_ren      (i_ren),
    .o_rdata    (o_rdata),
    .o_rvalid   (o_rvalid),
    .o_misalign (o_misalign)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_NS / 2) i_clk = ~i_clk;
  end

  function automatic int size_of(mem_pkg::memop_e op);
    case (op)
      mem_pkg::MEM_LB, mem_pkg::MEM_LBU: return 1;
      mem_pkg::MEM_LH, mem_pkg::MEM_LHU: return 2;
      mem_pkg::MEM_LW, mem_pkg::MEM_LWU: return 4;
      default:                           return 8;
    endcase
  endfunction

  // gather bytes from the shadow and extend
  function automatic logic [63:0] load_value(logic [7:0] idx, logic [2:0] off,
                                             mem_pkg::memop_e op);
    int          n;
    logic [63:0] v;
    logic [2:0]  code;
    logic        sbit;
    n    = size_of(op);
    code = op;
    v    = '0;
    for (int b = 0; b < n; b++) begin
      v = v | (64'(shadow[idx][off + 3'(b)]) << (8 * b));
    end
    sbit = |(v & (64'd1 << (8 * n - 1)));
    if (!code[0] && n < 8 && sbit) begin
      v = v | (~64'd0 << (8 * n));  // even codes sign extend
    end
    return v;
  endfunction

  function automatic logic [63:0] make_addr(logic [52:0] hi, logic [7:0] idx,
                                            logic [2:0] off);
    return {hi, idx, off};  // upper bits wrap away
  endfunction

  function automatic logic [63:0] fill_word(logic [7:0] idx);
    return (64'h9e37_79b9_7f4a_7c15 * 64'(idx)) + {8{idx}};
  endfunction

  // reference model stepped on every clock edge
  always @(posedge i_clk or negedge i_rst_n) begin
    int         n;
    logic       wr;
    logic       rd;
    logic       mis;
    logic [7:0] idx;
    logic [2:0] off;
    if (!i_rst_n) begin
      exp_mis    <= 1'b0;
      exp_rvalid <= 1'b0;
      exp_rdata  <= '0;
      s1_v       <= 1'b0;
    end else begin
      n   = size_of(i_memop);
      idx = i_addr[10:3];
      off = i_addr[2:0];
      wr  = i_wen && (i_memop != mem_pkg::MEM_NONE);
      rd  = i_ren && !i_wen && (i_memop != mem_pkg::MEM_NONE);  // write wins
      mis = (wr || rd) && ((int'(off) % n) != 0);
      exp_mis    <= mis;
      exp_rvalid <= s1_v;
      exp_rdata  <= s1_v ? s1_d : '0;
      s1_v       <= rd && !mis;
      if (rd && !mis) begin
        s1_d <= load_value(idx, off, i_memop);
      end
      if (wr && !mis) begin
        for (int b = 0; b < n; b++) begin
          shadow[idx][off + 3'(b)] = 8'(i_wdata >> (8 * b));
        end
      end
    end
  end

  a_rvalid: assert property (@(posedge i_clk) o_rvalid === exp_rvalid)
    else begin
      err_pulse = err_pulse + 1;
      $display("o_rvalid pulse %s at %0t", exp_rvalid ? "missing" : "unexpected", $time);
    end

  a_misalign: assert property (@(posedge i_clk) o_misalign === exp_mis)
    else begin
      err_pulse = err_pulse + 1;
      $display("o_misalign pulse %s at %0t", exp_mis ? "missing" : "unexpected", $time);
    end

  a_rdata: assert property (@(posedge i_clk) o_rdata === exp_rdata)
    else begin
      err_data = err_data + 1;
      $display("FAILED o_rdata expected %h actual %h", exp_rdata, o_rdata);
    end

  task automatic req(logic wen, logic ren, mem_pkg::memop_e op, logic [63:0] addr,
                     logic [63:0] wdata);
    @(negedge i_clk);
    i_wen   = wen;
    i_ren   = ren;
    i_memop = op;
    i_addr  = addr;
    i_wdata = wdata;
  endtask

  initial begin
    #((PRE_CYCLES + N_RANDOM + 20) * CLK_NS);
    $display("watchdog timeout, simulation did not finish in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    logic [31:0]     r;
    logic [63:0]     wd;
    logic [52:0]     hi;
    mem_pkg::memop_e op;
    i_rst_n = 1'b1;
    i_wen   = 1'b0;
    i_ren   = 1'b0;
    i_memop = mem_pkg::MEM_NONE;
    i_addr  = '0;
    i_wdata = '0;
    #1 i_rst_n = 1'b0;  // clean falling edge on the async reset
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;

    for (int k = 0; k < FILL_WORDS; k++) begin
      req(1'b1, 1'b0, mem_pkg::MEM_LD, make_addr(53'(k), 8'(k), 3'd0), fill_word(8'(k)));
    end
    // doubleword round trip
    wd = {$random(seed), $random(seed)};
    req(1'b1, 1'b0, mem_pkg::MEM_LD, make_addr('0, 8'd5, 3'd0), wd);
    req(1'b0, 1'b1, mem_pkg::MEM_LD, make_addr('0, 8'd5, 3'd0), '0);
    // every opcode at every offset back to back
    for (int o = 0; o < 8; o++) begin
      for (int c = 0; c < 7; c++) begin
        req(1'b0, 1'b1, mem_pkg::memop_e'(3'(c)), make_addr(53'(o + 1), 8'd7, 3'(o)), '0);
      end
    end
    // sub-word stores then whole-word readback
    for (int o = 0; o < 8; o++) begin
      wd = {$random(seed), $random(seed)};
      req(1'b1, 1'b0, mem_pkg::MEM_LB, make_addr('0, 8'd8, 3'(o)), wd);
      req(1'b1, 1'b0, mem_pkg::MEM_LH, make_addr('0, 8'd9, 3'(o)), wd);
      req(1'b1, 1'b0, mem_pkg::MEM_LW, make_addr('0, 8'd10, 3'(o)), wd);
      req(1'b0, 1'b1, mem_pkg::MEM_LD, make_addr('0, 8'd8, 3'd0), '0);
      req(1'b0, 1'b1, mem_pkg::MEM_LD, make_addr('0, 8'd9, 3'd0), '0);
      req(1'b0, 1'b1, mem_pkg::MEM_LD, make_addr('0, 8'd10, 3'd0), '0);
    end
    // idle and conflict cases
    req(1'b1, 1'b0, mem_pkg::MEM_NONE, make_addr('0, 8'd11, 3'd0), '1);
    req(1'b0, 1'b1, mem_pkg::MEM_NONE, make_addr('0, 8'd11, 3'd0), '0);
    req(1'b0, 1'b0, mem_pkg::MEM_LW, make_addr('0, 8'd11, 3'd0), '1);
    req(1'b1, 1'b1, mem_pkg::MEM_LD, make_addr('0, 8'd11, 3'd0), 64'h8000_0000_dead_beef);
    req(1'b0, 1'b1, mem_pkg::MEM_LD, make_addr('0, 8'd11, 3'd0), '0);

    for (int i = 0; i < N_RANDOM; i++) begin
      r  = $random(seed);
      op = mem_pkg::memop_e'(r[5:3]);
      hi = 53'({$random(seed), $random(seed)});
      wd = {$random(seed), $random(seed)};
      case (r[2:0])
        3'd0, 3'd1, 3'd2: req(1'b1, 1'b0, op, make_addr(hi, {3'b000, r[13:9]}, r[8:6]), wd);
        3'd3, 3'd4, 3'd5: req(1'b0, 1'b1, op, make_addr(hi, {3'b000, r[13:9]}, r[8:6]), wd);
        3'd6:             req(1'b1, 1'b1, op, make_addr(hi, {3'b000, r[13:9]}, r[8:6]), wd);
        default:          req(1'b0, 1'b0, op, make_addr(hi, {3'b000, r[13:9]}, r[8:6]), wd);
      endcase
    end
    req(1'b0, 1'b0, mem_pkg::MEM_NONE, '0, '0);
    repeat (4) @(negedge i_clk);

    $display("errors: data %0d, pulse %0d", err_data, err_pulse);
    if (err_data + err_pulse == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
hw/mem_pkg.sv
hw/store_lane.sv
hw/load_lane.sv
hw/data_ram.sv
hw/mem_unit.sv
testbench/tb_mem_unit.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mem_unit
FILELIST  := list.f
BUILD_DIR := obj_dir

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)
